// File: dft_mem.f
+incdir+include
source/dft_data_pkg.sv
source/dft_ctrl_pkg.sv
source/dft_cfg_regs.sv
source/dft_mem_ctrl.sv
source/dft_sample_ram.sv
source/dft_bfly_core.sv
source/dft_mem_top.sv
testbench/tb_dft_mem_top.sv

// File: include/dft_settings.svh
//--------------------------------------------------------------------------
// DFT engine settings
// Widths, depth and pipeline latency shared by all blocks
//--------------------------------------------------------------------------
`ifndef DFT_SETTINGS_SVH
`define DFT_SETTINGS_SVH

// Sample component width, two's complement
`define DFT_DATA_W 16
// Twiddle width, Q1.14
`define DFT_TWDL_W 16

// Sample RAM depth and address width
`define DFT_MAX_PTS 16
`define DFT_ADDR_W 4

// Legal range of log2 of the point count
`define DFT_LOG2N_MIN 2
`define DFT_LOG2N_MAX 4

// Butterfly pipeline depth in cycles
`define DFT_BFLY_LAT 3

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the DFT engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f dft_mem.f \
	--top-module tb_dft_mem_top -o sim_dft_mem > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_dft_mem > sim.log 2>&1
cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// File: source/dft_bfly_core.sv
//--------------------------------------------------------------------------
// DFT radix-2 butterfly
// Three-stage pipeline, x = (a + W*b)/2 and y = (a - W*b)/2
//--------------------------------------------------------------------------
`include "dft_settings.svh"

module dft_bfly_core (
	input  logic                     clk,
	input  logic                     rst_n,
	input  dft_data_pkg::bfly_req_t  req,
	output dft_data_pkg::bfly_rsp_t  rsp
);

	localparam int PROD_W = `DFT_DATA_W + `DFT_TWDL_W + 1;
	localparam int ACC_W = PROD_W + 1;
	// Fraction bits of Q1.14
	localparam int FRAC = `DFT_TWDL_W - 2;

	// cos and -sin of 2*pi*k/16
	localparam logic signed [`DFT_TWDL_W-1:0] COS_ROM [8] =
		'{16384, 15137, 11585, 6270, 0, -6270, -11585, -15137};
	localparam logic signed [`DFT_TWDL_W-1:0] MSIN_ROM [8] =
		'{0, -6270, -11585, -15137, -16384, -15137, -11585, -6270};

	logic signed [`DFT_TWDL_W-1:0] w_re;
	logic signed [`DFT_TWDL_W-1:0] w_im;
	logic signed [PROD_W-1:0]      s1_p_re;
	logic signed [PROD_W-1:0]      s1_p_im;
	dft_data_pkg::cplx_t           s1_a;
	logic signed [ACC_W-1:0]       a_re_sc;
	logic signed [ACC_W-1:0]       a_im_sc;
	logic signed [ACC_W-1:0]       s2_sum_re;
	logic signed [ACC_W-1:0]       s2_sum_im;
	logic signed [ACC_W-1:0]       s2_dif_re;
	logic signed [ACC_W-1:0]       s2_dif_im;
	dft_data_pkg::cplx_t           s3_x;
	dft_data_pkg::cplx_t           s3_y;
	// Valid and addresses ride along the data stages
	logic [`DFT_BFLY_LAT-1:0]      vld_pipe;
	logic [`DFT_ADDR_W-1:0]        ax_pipe [`DFT_BFLY_LAT];
	logic [`DFT_ADDR_W-1:0]        ay_pipe [`DFT_BFLY_LAT];

	assign w_re = COS_ROM[req.twdl_idx];
	assign w_im = MSIN_ROM[req.twdl_idx];
	// a brought to the product scale
	assign a_re_sc = $signed(s1_a.re) <<< FRAC;
	assign a_im_sc = $signed(s1_a.im) <<< FRAC;

	always_ff @(posedge clk)
	begin
		// Stage 1, complex multiply at full precision
		s1_p_re <= $signed(req.b.re) * w_re - $signed(req.b.im) * w_im;
		s1_p_im <= $signed(req.b.re) * w_im + $signed(req.b.im) * w_re;
		s1_a <= req.a;
		// Stage 2
		s2_sum_re <= a_re_sc + s1_p_re;
		s2_sum_im <= a_im_sc + s1_p_im;
		s2_dif_re <= a_re_sc - s1_p_re;
		s2_dif_im <= a_im_sc - s1_p_im;
		// Stage 3, arithmetic shift by FRAC+1 drops scale and halves
		s3_x.re <= s2_sum_re[FRAC + `DFT_DATA_W : FRAC + 1];
		s3_x.im <= s2_sum_im[FRAC + `DFT_DATA_W : FRAC + 1];
		s3_y.re <= s2_dif_re[FRAC + `DFT_DATA_W : FRAC + 1];
		s3_y.im <= s2_dif_im[FRAC + `DFT_DATA_W : FRAC + 1];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[`DFT_BFLY_LAT-2:0], req.valid};
	end

	always_ff @(posedge clk)
	begin
		ax_pipe[0] <= req.addr_a;
		ay_pipe[0] <= req.addr_b;
		for (int i = 1; i < `DFT_BFLY_LAT; i++)
		begin
			ax_pipe[i] <= ax_pipe[i-1];
			ay_pipe[i] <= ay_pipe[i-1];
		end
	end

	always_comb
	begin
		rsp.valid = vld_pipe[`DFT_BFLY_LAT-1];
		rsp.x = s3_x;
		rsp.y = s3_y;
		rsp.addr_x = ax_pipe[`DFT_BFLY_LAT-1];
		rsp.addr_y = ay_pipe[`DFT_BFLY_LAT-1];
	end

endmodule

// File: source/dft_cfg_regs.sv
//--------------------------------------------------------------------------
// DFT configuration registers
// Four-phase req/ack slave with point-count register and frame counter
//--------------------------------------------------------------------------
`include "dft_settings.svh"

module dft_cfg_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cfg_req,
	input  dft_ctrl_pkg::cfg_cmd_t  cfg_cmd,
	output logic                    cfg_ack,
	output dft_ctrl_pkg::cfg_rsp_t  cfg_rsp,
	input  logic                    frame_done,
	output logic [2:0]              log2n
);

	logic [7:0] frame_cnt;
	logic       req_new;
	logic       set_ok;

	// First cycle of a request, ack still low
	assign req_new = cfg_req && !cfg_ack;
	// Point count must stay inside the RAM range
	assign set_ok = (cfg_cmd.data >= `DFT_LOG2N_MIN) && (cfg_cmd.data <= `DFT_LOG2N_MAX);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg_ack <= 1'b0;
			log2n <= 3'd3;
			frame_cnt <= 8'd0;
		end
		else
		begin
			// Ack trails req by one cycle in both directions
			cfg_ack <= cfg_req;
			// Wraps at 256
			if (frame_done)
				frame_cnt <= frame_cnt + 8'd1;
			if (req_new && cfg_cmd.op == dft_ctrl_pkg::CFG_SET_LOG2N && set_ok)
				log2n <= cfg_cmd.data[2:0];
		end
	end

	// Response captured with the command
	always_ff @(posedge clk)
	begin
		if (req_new)
		begin
			case (cfg_cmd.op)
				dft_ctrl_pkg::CFG_SET_LOG2N:
				begin
					cfg_rsp.data <= cfg_cmd.data;
					cfg_rsp.err <= !set_ok;
				end
				dft_ctrl_pkg::CFG_GET_LOG2N:
				begin
					cfg_rsp.data <= {5'd0, log2n};
					cfg_rsp.err <= 1'b0;
				end
				dft_ctrl_pkg::CFG_GET_FRAMES:
				begin
					cfg_rsp.data <= frame_cnt;
					cfg_rsp.err <= 1'b0;
				end
				default:
				begin
					// Unknown opcode
					cfg_rsp.data <= 8'd0;
					cfg_rsp.err <= 1'b1;
				end
			endcase
		end
	end

endmodule

// File: source/dft_ctrl_pkg.sv
//--------------------------------------------------------------------------
// DFT control types
// Controller states and the configuration command/response format
//--------------------------------------------------------------------------
package dft_ctrl_pkg;

	// Memory controller FSM states
	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_SINK    = 3'd1,
		ST_RD      = 3'd2,
		ST_WAIT_WR = 3'd3,
		ST_SOURCE  = 3'd4
	} ctrl_state_e;

	// Configuration opcodes
	typedef enum logic [1:0] {
		CFG_SET_LOG2N  = 2'd0,
		CFG_GET_LOG2N  = 2'd1,
		CFG_GET_FRAMES = 2'd2
	} cfg_op_e;

	// Host to register block
	typedef struct packed {
		cfg_op_e op;
		logic [7:0] data;
	} cfg_cmd_t;

	// Register block to host, valid while ack is high
	typedef struct packed {
		logic [7:0] data;
		logic err;
	} cfg_rsp_t;

endpackage

// File: source/dft_data_pkg.sv
//--------------------------------------------------------------------------
// DFT data path types
// Complex samples, stream beats and butterfly request/response
//--------------------------------------------------------------------------
`include "dft_settings.svh"

package dft_data_pkg;

	// One complex sample
	typedef struct packed {
		logic signed [`DFT_DATA_W-1:0] re;
		logic signed [`DFT_DATA_W-1:0] im;
	} cplx_t;

	// Stream beat, same shape for sink and source
	typedef struct packed {
		logic valid;
		logic sop;
		logic eop;
		cplx_t sample;
	} stream_t;

	// Butterfly operands with their in-place addresses
	typedef struct packed {
		logic valid;
		cplx_t a;
		cplx_t b;
		logic [`DFT_ADDR_W-1:0] addr_a;
		logic [`DFT_ADDR_W-1:0] addr_b;
		// Angle index, 2*pi*k/16
		logic [2:0] twdl_idx;
	} bfly_req_t;

	// Butterfly results, addresses travel along
	typedef struct packed {
		logic valid;
		cplx_t x;
		cplx_t y;
		logic [`DFT_ADDR_W-1:0] addr_x;
		logic [`DFT_ADDR_W-1:0] addr_y;
	} bfly_rsp_t;

endpackage

// File: source/dft_mem_ctrl.sv
//--------------------------------------------------------------------------
// DFT memory controller
// Sinks a frame bit-reversed, runs in-place radix-2 stages through the
// butterfly core, then sources the bins in natural order
//--------------------------------------------------------------------------
`include "dft_settings.svh"

module dft_mem_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [2:0]                 log2n,
	input  dft_data_pkg::stream_t      in_stream,
	output logic                       sink_ready,
	output dft_data_pkg::stream_t      out_stream,
	output logic                       frame_done,
	output logic                       we_a,
	output logic [`DFT_ADDR_W-1:0]     waddr_a,
	output dft_data_pkg::cplx_t        wdata_a,
	output logic                       we_b,
	output logic [`DFT_ADDR_W-1:0]     waddr_b,
	output dft_data_pkg::cplx_t        wdata_b,
	output logic [`DFT_ADDR_W-1:0]     raddr_a,
	output logic [`DFT_ADDR_W-1:0]     raddr_b,
	input  dft_data_pkg::cplx_t        rdata_a,
	input  dft_data_pkg::cplx_t        rdata_b,
	output dft_data_pkg::bfly_req_t    bfly_req,
	input  dft_data_pkg::bfly_rsp_t    bfly_rsp
);

	dft_ctrl_pkg::ctrl_state_e state;
	// Frame size, latched at frame start
	logic [2:0]                n_log2;
	logic [`DFT_ADDR_W-1:0]    last_idx;
	logic [`DFT_ADDR_W-2:0]    last_bf;
	// Counters
	logic [`DFT_ADDR_W-1:0]    sink_cnt;
	logic [1:0]                stage_cnt;
	logic [`DFT_ADDR_W-2:0]    bf_cnt;
	logic [`DFT_ADDR_W-2:0]    wr_cnt;
	logic [`DFT_ADDR_W-1:0]    src_cnt;
	logic                      src_end;
	logic                      sink_first;
	logic                      sink_we;
	logic                      src_rd;
	logic                      last_stage;
	// Butterfly address generation
	logic [`DFT_ADDR_W-1:0]    hspan;
	logic [`DFT_ADDR_W-1:0]    lo_mask;
	logic [`DFT_ADDR_W-1:0]    bf_ext;
	logic [`DFT_ADDR_W-1:0]    bf_addr_a;
	logic [`DFT_ADDR_W-1:0]    bf_addr_b;
	logic [2:0]                twdl_idx;
	// Aligned with the one-cycle RAM read
	logic                      rd_vld_q;
	logic [`DFT_ADDR_W-1:0]    rd_addr_a_q;
	logic [`DFT_ADDR_W-1:0]    rd_addr_b_q;
	logic [2:0]                rd_twdl_q;
	logic                      src_vld_q;
	logic                      src_sop_q;
	logic                      src_eop_q;

	// Reverse the low lg bits of idx
	function automatic logic [`DFT_ADDR_W-1:0] bit_rev(input logic [`DFT_ADDR_W-1:0] idx,
		input logic [2:0] lg);
		logic [`DFT_ADDR_W-1:0] rev;
		for (int i = 0; i < `DFT_ADDR_W; i++)
			rev[i] = idx[`DFT_ADDR_W-1-i];
		return rev >> (`DFT_LOG2N_MAX - lg);
	endfunction

	// N-1 and N/2-1
	assign last_idx = {`DFT_ADDR_W{1'b1}} >> (`DFT_LOG2N_MAX - n_log2);
	assign last_bf = last_idx[`DFT_ADDR_W-1:1];
	assign last_stage = ({1'b0, stage_cnt} == n_log2 - 3'd1);

	assign sink_ready = (state == dft_ctrl_pkg::ST_IDLE);
	assign sink_first = sink_ready && in_stream.valid && in_stream.sop;
	assign sink_we = sink_first || (state == dft_ctrl_pkg::ST_SINK && in_stream.valid);
	assign src_rd = (state == dft_ctrl_pkg::ST_SOURCE) && !src_end;

	// Insert a zero at bit stage_cnt, partner has it set
	assign hspan = {{(`DFT_ADDR_W-1){1'b0}}, 1'b1} << stage_cnt;
	assign lo_mask = hspan - 1'b1;
	assign bf_ext = {1'b0, bf_cnt};
	assign bf_addr_a = ((bf_ext & ~lo_mask) << 1) | (bf_ext & lo_mask);
	assign bf_addr_b = bf_addr_a | hspan;
	// Angle p/(2h) of a turn, in sixteenths
	assign twdl_idx = (bf_cnt & lo_mask[`DFT_ADDR_W-2:0]) << (2'd3 - stage_cnt);

	//--------------------------------------------------------------------------
	// FSM and counters
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= dft_ctrl_pkg::ST_IDLE;
			n_log2 <= 3'd3;
			sink_cnt <= '0;
			stage_cnt <= 2'd0;
			bf_cnt <= '0;
			wr_cnt <= '0;
			src_cnt <= '0;
			src_end <= 1'b0;
		end
		else
		begin
			// Write-backs counted per stage
			if (bfly_rsp.valid)
				wr_cnt <= (wr_cnt == last_bf) ? '0 : wr_cnt + 1'b1;
			case (state)
				dft_ctrl_pkg::ST_IDLE:
				begin
					// First beat lands at address 0
					if (sink_first)
					begin
						state <= dft_ctrl_pkg::ST_SINK;
						n_log2 <= log2n;
						sink_cnt <= {{(`DFT_ADDR_W-1){1'b0}}, 1'b1};
					end
				end
				dft_ctrl_pkg::ST_SINK:
				begin
					if (in_stream.valid)
					begin
						sink_cnt <= sink_cnt + 1'b1;
						if (sink_cnt == last_idx)
						begin
							sink_cnt <= '0;
							stage_cnt <= 2'd0;
							bf_cnt <= '0;
							state <= dft_ctrl_pkg::ST_RD;
						end
					end
				end
				dft_ctrl_pkg::ST_RD:
				begin
					// One butterfly read per cycle
					bf_cnt <= bf_cnt + 1'b1;
					if (bf_cnt == last_bf)
					begin
						bf_cnt <= '0;
						state <= dft_ctrl_pkg::ST_WAIT_WR;
					end
				end
				dft_ctrl_pkg::ST_WAIT_WR:
				begin
					// Next stage only after the last write-back
					if (bfly_rsp.valid && wr_cnt == last_bf)
					begin
						if (last_stage)
						begin
							src_cnt <= '0;
							src_end <= 1'b0;
							state <= dft_ctrl_pkg::ST_SOURCE;
						end
						else
						begin
							stage_cnt <= stage_cnt + 2'd1;
							state <= dft_ctrl_pkg::ST_RD;
						end
					end
				end
				dft_ctrl_pkg::ST_SOURCE:
				begin
					if (src_rd)
					begin
						src_cnt <= src_cnt + 1'b1;
						if (src_cnt == last_idx)
							src_end <= 1'b1;
					end
					// Stay until the last bin is out
					if (src_eop_q)
						state <= dft_ctrl_pkg::ST_IDLE;
				end
				default:
					state <= dft_ctrl_pkg::ST_IDLE;
			endcase
		end
	end

	//--------------------------------------------------------------------------
	// Read pipeline, one cycle behind the address
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_vld_q <= 1'b0;
			src_vld_q <= 1'b0;
			src_sop_q <= 1'b0;
			src_eop_q <= 1'b0;
		end
		else
		begin
			rd_vld_q <= (state == dft_ctrl_pkg::ST_RD);
			src_vld_q <= src_rd;
			src_sop_q <= src_rd && (src_cnt == '0);
			src_eop_q <= src_rd && (src_cnt == last_idx);
		end
	end

	always_ff @(posedge clk)
	begin
		rd_addr_a_q <= bf_addr_a;
		rd_addr_b_q <= bf_addr_b;
		rd_twdl_q <= twdl_idx;
	end

	//--------------------------------------------------------------------------
	// RAM ports
	always_comb
	begin
		// Port a shared by sink and x write-back, never both at once
		we_a = sink_we || bfly_rsp.valid;
		waddr_a = sink_we ? bit_rev(sink_cnt, n_log2) : bfly_rsp.addr_x;
		wdata_a = sink_we ? in_stream.sample : bfly_rsp.x;
		we_b = bfly_rsp.valid;
		waddr_b = bfly_rsp.addr_y;
		wdata_b = bfly_rsp.y;
		raddr_a = (state == dft_ctrl_pkg::ST_SOURCE) ? src_cnt : bf_addr_a;
		raddr_b = bf_addr_b;
	end

	// Butterfly request and output stream from read data
	always_comb
	begin
		bfly_req.valid = rd_vld_q;
		bfly_req.a = rdata_a;
		bfly_req.b = rdata_b;
		bfly_req.addr_a = rd_addr_a_q;
		bfly_req.addr_b = rd_addr_b_q;
		bfly_req.twdl_idx = rd_twdl_q;
		out_stream.valid = src_vld_q;
		out_stream.sop = src_sop_q;
		out_stream.eop = src_eop_q;
		out_stream.sample = rdata_a;
	end

	assign frame_done = src_eop_q;

	// In-flight butterflies never collide on write-back
	a_wr_ports_distinct: assert property (@(posedge clk) disable iff (!rst_n)
		we_a && we_b |-> waddr_a != waddr_b);
	// Output only while sourcing
	a_out_in_source: assert property (@(posedge clk) disable iff (!rst_n)
		out_stream.valid |-> state == dft_ctrl_pkg::ST_SOURCE);

endmodule

// File: source/dft_mem_top.sv
//--------------------------------------------------------------------------
// DFT memory engine top
// Config registers, memory controller, sample RAM and butterfly core
//--------------------------------------------------------------------------
`include "dft_settings.svh"

module dft_mem_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  dft_data_pkg::stream_t   in_stream,
	output logic                    sink_ready,
	output dft_data_pkg::stream_t   out_stream,
	input  logic                    cfg_req,
	input  dft_ctrl_pkg::cfg_cmd_t  cfg_cmd,
	output logic                    cfg_ack,
	output dft_ctrl_pkg::cfg_rsp_t  cfg_rsp
);

	// Register block to controller
	logic [2:0]                log2n;
	logic                      frame_done;

	// Controller to RAM
	logic                      we_a;
	logic [`DFT_ADDR_W-1:0]    waddr_a;
	dft_data_pkg::cplx_t       wdata_a;
	logic                      we_b;
	logic [`DFT_ADDR_W-1:0]    waddr_b;
	dft_data_pkg::cplx_t       wdata_b;
	logic [`DFT_ADDR_W-1:0]    raddr_a;
	logic [`DFT_ADDR_W-1:0]    raddr_b;
	dft_data_pkg::cplx_t       rdata_a;
	dft_data_pkg::cplx_t       rdata_b;

	// Controller to butterfly
	dft_data_pkg::bfly_req_t   bfly_req;
	dft_data_pkg::bfly_rsp_t   bfly_rsp;

	dft_cfg_regs i_cfg_regs (.*);

	dft_mem_ctrl i_mem_ctrl (.*);

	dft_sample_ram i_sample_ram (.*);

	dft_bfly_core i_bfly_core (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (bfly_req),
		.rsp   (bfly_rsp)
	);

endmodule

// File: source/dft_sample_ram.sv
//--------------------------------------------------------------------------
// DFT sample RAM
// Two write and two registered read ports, one butterfly in and out per cycle
//--------------------------------------------------------------------------
`include "dft_settings.svh"

module dft_sample_ram (
	input  logic                    clk,
	input  logic                    we_a,
	input  logic [`DFT_ADDR_W-1:0]  waddr_a,
	input  dft_data_pkg::cplx_t     wdata_a,
	input  logic                    we_b,
	input  logic [`DFT_ADDR_W-1:0]  waddr_b,
	input  dft_data_pkg::cplx_t     wdata_b,
	input  logic [`DFT_ADDR_W-1:0]  raddr_a,
	input  logic [`DFT_ADDR_W-1:0]  raddr_b,
	output dft_data_pkg::cplx_t     rdata_a,
	output dft_data_pkg::cplx_t     rdata_b
);

	dft_data_pkg::cplx_t mem [`DFT_MAX_PTS];

	// Read returns the old word on a same-address write
	always_ff @(posedge clk)
	begin
		if (we_a)
			mem[waddr_a] <= wdata_a;
		if (we_b)
			mem[waddr_b] <= wdata_b;
		rdata_a <= mem[raddr_a];
		rdata_b <= mem[raddr_b];
	end

endmodule

// File: testbench/tb_dft_mem_top.sv
//--------------------------------------------------------------------------
// Testbench for the DFT memory engine
// Directed configuration, impulse, DC, tone and frame-counter tests
// checked against a real-valued DFT model
//--------------------------------------------------------------------------
`include "dft_settings.svh"

module tb_dft_mem_top;

	timeunit 1ns;
	timeprecision 100ps;

	// Seven frames of at most ~200 cycles plus config traffic, wide margin
	localparam int TIMEOUT_CYCLES = 4000;
	// Truncation in the butterflies, non-trivial inputs only
	localparam int TONE_TOL = 2;
	localparam int TONE_AMP = 3000;
	localparam real PI = 3.14159265358979;

	logic                   clk = 1'b0;
	logic                   rst_n;
	dft_data_pkg::stream_t  in_stream;
	dft_data_pkg::stream_t  out_stream;
	logic                   sink_ready;
	logic                   cfg_req;
	dft_ctrl_pkg::cfg_cmd_t cfg_cmd;
	logic                   cfg_ack;
	dft_ctrl_pkg::cfg_rsp_t cfg_rsp;

	integer seed = 32'h9f435e4b;
	int     cycle_cnt = 0;
	int     frames_seen = 0;
	string  test_name = "reset";
	// Input samples, model bins and captured bins
	int in_re [`DFT_MAX_PTS];
	int in_im [`DFT_MAX_PTS];
	int exp_re [`DFT_MAX_PTS];
	int exp_im [`DFT_MAX_PTS];
	int out_re [`DFT_MAX_PTS];
	int out_im [`DFT_MAX_PTS];

	dft_mem_top i_dut (.*);

	always #50 clk = ~clk;

	// Hang guard
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Simulation hang in %s, no end after %0d cycles", test_name, cycle_cnt);
			$display("TESTBENCH FAILED");
			$fatal(1, "Timeout");
		end
	end

	// Compare with a symmetric tolerance
	task automatic check(input string label, input int expected, input int actual, input int tol);
		int diff;
		diff = expected - actual;
		if (diff > tol || diff < -tol)
		begin
			$display("Fail %s %s: expected %0d, actual %0d", test_name, label, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch in %s", test_name);
		end
	endtask

	//--------------------------------------------------------------------------
	// Four-phase config exchange, ack one cycle behind req both ways
	task automatic handshake(input dft_ctrl_pkg::cfg_op_e op, input logic [7:0] data,
		output dft_ctrl_pkg::cfg_rsp_t rsp);
		check("ack before req", 0, cfg_ack, 0);
		cfg_cmd.op = op;
		cfg_cmd.data = data;
		cfg_req = 1'b1;
		@(negedge clk);
		check("ack rise", 1, cfg_ack, 0);
		rsp = cfg_rsp;
		cfg_req = 1'b0;
		@(negedge clk);
		check("ack fall", 0, cfg_ack, 0);
	endtask

	task automatic cfg_write(input int lg, input bit exp_err);
		dft_ctrl_pkg::cfg_rsp_t rsp;
		handshake(dft_ctrl_pkg::CFG_SET_LOG2N, 8'(lg), rsp);
		check("set err", exp_err, rsp.err, 0);
	endtask

	task automatic cfg_read(input dft_ctrl_pkg::cfg_op_e op, output int value);
		dft_ctrl_pkg::cfg_rsp_t rsp;
		handshake(op, 8'd0, rsp);
		check("get err", 0, rsp.err, 0);
		value = rsp.data;
	endtask

	//--------------------------------------------------------------------------
	// Stream helpers
	task automatic send_frame(input int n, input bit gaps);
		int gap;
		for (int i = 0; i < n; i++)
		begin
			// Idle beats between samples, never before sop
			if (gaps && i > 0)
			begin
				gap = $unsigned($random(seed)) % 3;
				in_stream = '0;
				repeat (gap)
				begin
					@(negedge clk);
					check("sink_ready in gap", 0, sink_ready, 0);
				end
			end
			if (i == 0)
				check("sink_ready at sop", 1, sink_ready, 0);
			in_stream.valid = 1'b1;
			in_stream.sop = (i == 0);
			in_stream.eop = (i == n - 1);
			in_stream.sample.re = 16'(in_re[i]);
			in_stream.sample.im = 16'(in_im[i]);
			@(negedge clk);
			check("sink_ready in frame", 0, sink_ready, 0);
		end
		in_stream = '0;
	endtask

	task automatic collect_frame(input int n);
		while (!out_stream.valid)
		begin
			// Engine busy with the stages
			check("sink_ready while busy", 0, sink_ready, 0);
			@(negedge clk);
		end
		for (int i = 0; i < n; i++)
		begin
			check("out valid", 1, out_stream.valid, 0);
			check("out sop", (i == 0), out_stream.sop, 0);
			check("out eop", (i == n - 1), out_stream.eop, 0);
			check("sink_ready in source", 0, sink_ready, 0);
			out_re[i] = $signed(out_stream.sample.re);
			out_im[i] = $signed(out_stream.sample.im);
			@(negedge clk);
		end
		check("out valid after eop", 0, out_stream.valid, 0);
		check("sink_ready after eop", 1, sink_ready, 0);
		frames_seen++;
	endtask

	// Reference DFT scaled by 1/N
	task automatic compare_bins(input int n, input int tol);
		real acc_re;
		real acc_im;
		real ang;
		for (int k = 0; k < n; k++)
		begin
			acc_re = 0.0;
			acc_im = 0.0;
			for (int m = 0; m < n; m++)
			begin
				ang = 2.0 * PI * k * m / n;
				acc_re += in_re[m] * $cos(ang) + in_im[m] * $sin(ang);
				acc_im += in_im[m] * $cos(ang) - in_re[m] * $sin(ang);
			end
			exp_re[k] = int'(acc_re / n);
			exp_im[k] = int'(acc_im / n);
			check($sformatf("bin %0d re", k), exp_re[k], out_re[k], tol);
			check($sformatf("bin %0d im", k), exp_im[k], out_im[k], tol);
		end
	endtask

	task automatic fill_tone(input int n, input int k);
		real ang;
		for (int m = 0; m < n; m++)
		begin
			ang = 2.0 * PI * k * m / n;
			in_re[m] = int'(TONE_AMP * $cos(ang));
			in_im[m] = int'(TONE_AMP * $sin(ang));
		end
	endtask

	//--------------------------------------------------------------------------
	// Directed tests
	task automatic config_regs();
		int value;
		test_name = "config";
		cfg_read(dft_ctrl_pkg::CFG_GET_LOG2N, value);
		check("reset log2n", 3, value, 0);
		cfg_write(4, 1'b0);
		cfg_read(dft_ctrl_pkg::CFG_GET_LOG2N, value);
		check("log2n after set", 4, value, 0);
		// Out of range, register keeps 4
		cfg_write(6, 1'b1);
		cfg_read(dft_ctrl_pkg::CFG_GET_LOG2N, value);
		check("log2n after bad set", 4, value, 0);
	endtask

	task automatic impulse_n8();
		test_name = "impulse n=8";
		cfg_write(3, 1'b0);
		for (int m = 0; m < 8; m++)
		begin
			in_re[m] = (m == 0) ? 1024 : 0;
			in_im[m] = 0;
		end
		send_frame(8, 1'b0);
		collect_frame(8);
		compare_bins(8, 0);
	endtask

	task automatic dc_gaps_n16();
		test_name = "dc n=16";
		cfg_write(4, 1'b0);
		for (int m = 0; m < 16; m++)
		begin
			in_re[m] = 800;
			in_im[m] = -400;
		end
		send_frame(16, 1'b1);
		collect_frame(16);
		compare_bins(16, 0);
	endtask

	task automatic tone_sweep();
		int n;
		int k;
		for (int lg = `DFT_LOG2N_MIN; lg <= `DFT_LOG2N_MAX; lg++)
		begin
			n = 1 << lg;
			k = $unsigned($random(seed)) % n;
			test_name = $sformatf("tone n=%0d k=%0d", n, k);
			cfg_write(lg, 1'b0);
			fill_tone(n, k);
			send_frame(n, 1'b1);
			collect_frame(n);
			compare_bins(n, TONE_TOL);
		end
	endtask

	task automatic deferred_length();
		int value;
		test_name = "deferred config";
		cfg_write(4, 1'b0);
		fill_tone(16, 5);
		send_frame(16, 1'b0);
		// Frame in flight, new size only for the next one
		cfg_write(2, 1'b0);
		collect_frame(16);
		compare_bins(16, TONE_TOL);
		fill_tone(4, 1);
		send_frame(4, 1'b0);
		collect_frame(4);
		compare_bins(4, TONE_TOL);
		cfg_read(dft_ctrl_pkg::CFG_GET_FRAMES, value);
		check("frame count", frames_seen, value, 0);
	endtask

	initial
	begin
		rst_n = 1'b0;
		cfg_req = 1'b0;
		cfg_cmd = '0;
		in_stream = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check("sink_ready", 1, sink_ready, 0);
		check("out valid", 0, out_stream.valid, 0);
		check("cfg_ack", 0, cfg_ack, 0);
		config_regs();
		impulse_n8();
		dc_gaps_n16();
		tone_sweep();
		deferred_length();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
